// File: source/alu_pkg.sv
// alu package with opcodes, register map, flag positions and adder group width
package alu_pkg;

   // opcode field of the control register, codes 5 to 7 are illegal
   typedef enum logic [2:0] {
      op_add = 3'd0,
      op_sub = 3'd1,
      op_sal = 3'd2,
      op_shr = 3'd3,
      op_sar = 3'd4
   } alu_op_t;

   // apb address bits
   localparam int apb_addr_width = 5;

   // register offsets
   localparam logic [apb_addr_width-1:0] addr_operand_a = 5'h00;
   localparam logic [apb_addr_width-1:0] addr_operand_b = 5'h04;
   localparam logic [apb_addr_width-1:0] addr_control   = 5'h08;
   localparam logic [apb_addr_width-1:0] addr_result    = 5'h0C;
   localparam logic [apb_addr_width-1:0] addr_flags     = 5'h10;

   // bit positions in the flags register
   localparam int flag_cf   = 0;
   localparam int flag_af   = 1;
   localparam int flag_zf   = 2;
   localparam int flag_sf   = 3;
   localparam int flag_of   = 4;
   localparam int num_flags = 5;

   // bits per lookahead group
   localparam int cla_group_width = 4;

endpackage

// File: source/alu_cla_adder.sv
// carry-lookahead adder built from 4-bit groups with a second lookahead level
`timescale 1ns/1ns
module alu_cla_adder import alu_pkg::*; #(
   parameter int data_width = 32
) (
   input  logic [data_width-1:0] a,
   input  logic [data_width-1:0] b,
   input  logic                  cin,
   output logic [data_width-1:0] sum,
   output logic                  cout,
   output logic                  aux_carry,
   output logic                  overflow
);

   localparam int num_groups = data_width / cla_group_width;

   logic [data_width-1:0] p;
   logic [data_width-1:0] g;
   wire  [data_width:0]   c;
   wire  [num_groups-1:0] grp_p;
   wire  [num_groups-1:0] grp_g;
   logic [num_groups:0]   grp_c;

   // bit propagate and generate
   assign p = a ^ b;
   assign g = a & b;

   for (genvar n = 0; n < num_groups; n++) begin : gen_group
      logic [cla_group_width-1:0] gp;
      logic [cla_group_width-1:0] gg;
      logic [cla_group_width-1:0] carry;
      logic                       grp_prop;
      logic                       grp_gen;

      assign gp = p[n*cla_group_width +: cla_group_width];
      assign gg = g[n*cla_group_width +: cla_group_width];

      // group p and g, independent of the group carry-in
      always_comb begin
         grp_prop = 1'b1;
         grp_gen  = 1'b0;
         for (int k = 0; k < cla_group_width; k++) begin
            grp_gen  = gg[k] | (gp[k] & grp_gen);
            grp_prop = grp_prop & gp[k];
         end
      end

      // carries inside the group from the lookahead carry-in
      always_comb begin
         carry[0] = grp_c[n];
         for (int k = 1; k < cla_group_width; k++) begin
            carry[k] = gg[k-1] | (gp[k-1] & carry[k-1]);
         end
      end

      assign grp_p[n] = grp_prop;
      assign grp_g[n] = grp_gen;
      assign c[n*cla_group_width +: cla_group_width] = carry;
   end

   // second level across the groups
   always_comb begin
      grp_c[0] = cin;
      for (int n = 0; n < num_groups; n++) begin
         grp_c[n+1] = grp_g[n] | (grp_p[n] & grp_c[n]);
      end
   end

   assign c[data_width] = grp_c[num_groups];

   assign sum       = p ^ c[data_width-1:0];
   assign cout      = c[data_width];
   // carry out of bit 3
   assign aux_carry = c[cla_group_width];
   assign overflow  = c[data_width] ^ c[data_width-1];

endmodule

// File: source/alu_barrel_shifter.sv
// logarithmic barrel shifter for arithmetic left and logical or arithmetic right
`timescale 1ns/1ns
module alu_barrel_shifter #(
   parameter int data_width = 32
) (
   input  logic [data_width-1:0]         data,
   input  logic [$clog2(data_width)-1:0] count,
   input  logic                          shift_left,
   input  logic                          arithmetic,
   output logic [data_width-1:0]         shifted
);

   localparam int count_width = $clog2(data_width);

   logic [data_width-1:0] stage [0:count_width];
   logic                  fill;

   // sign fill only for sar
   assign fill     = arithmetic & ~shift_left & data[data_width-1];
   assign stage[0] = data;

   // largest step first, half the width down to one
   for (genvar i = 0; i < count_width; i++) begin : gen_stage
      localparam int bit_sel = count_width - 1 - i;
      localparam int amount  = 1 << bit_sel;

      logic [data_width-1:0] moved;

      assign moved = shift_left ?
                     {stage[i][data_width-1-amount:0], {amount{1'b0}}} :
                     {{amount{fill}}, stage[i][data_width-1:amount]};

      assign stage[i+1] = count[bit_sel] ? moved : stage[i];
   end

   assign shifted = stage[count_width];

endmodule

// File: source/alu_exec.sv
// alu execution unit, selects adder or shifter and forms the flags
`timescale 1ns/1ns
module alu_exec import alu_pkg::*; #(
   parameter int data_width = 32
) (
   input  logic [data_width-1:0] operand_a,
   input  logic [data_width-1:0] operand_b,
   input  alu_op_t               op,
   output logic [data_width-1:0] exec_result,
   output logic [num_flags-1:0]  exec_flags
);

   localparam int count_width = $clog2(data_width);

   logic                  is_sub;
   logic [data_width-1:0] add_b;
   logic [data_width-1:0] sum;
   logic                  cout;
   logic                  aux_carry;
   logic                  overflow;
   logic [data_width-1:0] shifted;

   // subtract as a + ~b + 1
   assign is_sub = (op == op_sub);
   assign add_b  = is_sub ? ~operand_b : operand_b;

   alu_cla_adder #(
      .data_width(data_width)
   ) i_adder (
      .a         (operand_a),
      .b         (add_b),
      .cin       (is_sub),
      .sum       (sum),
      .cout      (cout),
      .aux_carry (aux_carry),
      .overflow  (overflow)
   );

   alu_barrel_shifter #(
      .data_width(data_width)
   ) i_shifter (
      .data       (operand_a),
      .count      (operand_b[count_width-1:0]),
      .shift_left (op == op_sal),
      .arithmetic (op == op_sar),
      .shifted    (shifted)
   );

   always_comb begin
      exec_flags = '0;
      case (op)
         op_add, op_sub: begin
            exec_result = sum;
            // borrow is the inverted carry on subtract
            exec_flags[flag_cf] = cout ^ is_sub;
            exec_flags[flag_af] = aux_carry ^ is_sub;
            exec_flags[flag_of] = overflow;
         end
         default: exec_result = shifted;
      endcase
      exec_flags[flag_zf] = ~|exec_result;
      exec_flags[flag_sf] = exec_result[data_width-1];
   end

endmodule

// File: source/alu_apb_regs.sv
// alu apb register bank, holds operands and opcode and launches operations
`timescale 1ns/1ns
module alu_apb_regs import alu_pkg::*; #(
   parameter int data_width = 32
) (
   input  logic                      pclk,
   input  logic                      arst_n,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_addr_width-1:0] paddr,
   input  logic [data_width-1:0]     pwdata,
   input  logic [data_width-1:0]     result,
   input  logic [num_flags-1:0]      flags,
   output logic [data_width-1:0]     prdata,
   output logic                      pready,
   output logic                      pslverr,
   output logic [data_width-1:0]     operand_a,
   output logic [data_width-1:0]     operand_b,
   output alu_op_t                   op,
   output logic                      launch
);

   logic access;
   logic wr_access;
   logic rd_access;
   logic addr_mapped;
   logic op_legal;
   logic wr_error;

   // zero wait states, every access phase completes
   assign pready    = 1'b1;
   assign access    = psel & penable;
   assign wr_access = access & pwrite;
   assign rd_access = access & ~pwrite;

   always_comb begin
      case (paddr)
         addr_operand_a, addr_operand_b, addr_control, addr_result, addr_flags:
            addr_mapped = 1'b1;
         default:
            addr_mapped = 1'b0;
      endcase
   end

   always_comb begin
      case (pwdata[2:0])
         op_add, op_sub, op_sal, op_shr, op_sar: op_legal = 1'b1;
         default:                                op_legal = 1'b0;
      endcase
   end

   // result and flags are read-only
   assign wr_error = wr_access & ((paddr == addr_result) | (paddr == addr_flags) |
                                  ((paddr == addr_control) & ~op_legal));
   assign pslverr  = (access & ~addr_mapped) | wr_error;

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         operand_a <= '0;
         operand_b <= '0;
         op        <= op_add;
         launch    <= 1'b0;
      end else begin
         launch <= 1'b0;
         if (wr_access) begin
            case (paddr)
               addr_operand_a: operand_a <= pwdata;
               addr_operand_b: operand_b <= pwdata;
               addr_control: begin
                  // illegal opcode leaves op and result untouched
                  if (op_legal) begin
                     op     <= alu_op_t'(pwdata[2:0]);
                     launch <= 1'b1;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // combinational read data so a result loaded at the access edge is seen
   always_comb begin
      prdata = '0;
      if (rd_access) begin
         case (paddr)
            addr_operand_a: prdata = operand_a;
            addr_operand_b: prdata = operand_b;
            addr_result:    prdata = result;
            addr_flags:     prdata = {{(data_width-num_flags){1'b0}}, flags};
            default:        prdata = '0;
         endcase
      end
   end

endmodule

// File: source/alu_result_regs.sv
// alu result and flag registers, loaded on the launch pulse
`timescale 1ns/1ns
module alu_result_regs import alu_pkg::*; #(
   parameter int data_width = 32
) (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic                  launch,
   input  logic [data_width-1:0] exec_result,
   input  logic [num_flags-1:0]  exec_flags,
   output logic [data_width-1:0] result,
   output logic [num_flags-1:0]  flags
);

   // hold the last completed operation
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
         flags  <= '0;
      end else if (launch) begin
         result <= exec_result;
         flags  <= exec_flags;
      end
   end

endmodule

// File: source/alu_apb_top.sv
// apb integer alu top level, register bank, execution unit and result registers
`timescale 1ns/1ns
module alu_apb_top import alu_pkg::*; #(
   parameter int data_width = 32
) (
   input  logic                      pclk,
   input  logic                      arst_n,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_addr_width-1:0] paddr,
   input  logic [data_width-1:0]     pwdata,
   output logic [data_width-1:0]     prdata,
   output logic                      pready,
   output logic                      pslverr
);

   logic [data_width-1:0] operand_a;
   logic [data_width-1:0] operand_b;
   alu_op_t               op;
   logic                  launch;
   logic [data_width-1:0] exec_result;
   logic [num_flags-1:0]  exec_flags;
   logic [data_width-1:0] result;
   logic [num_flags-1:0]  flags;

   alu_apb_regs #(
      .data_width(data_width)
   ) i_regs (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .result    (result),
      .flags     (flags),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .op        (op),
      .launch    (launch)
   );

   alu_exec #(
      .data_width(data_width)
   ) i_exec (
      .operand_a   (operand_a),
      .operand_b   (operand_b),
      .op          (op),
      .exec_result (exec_result),
      .exec_flags  (exec_flags)
   );

   alu_result_regs #(
      .data_width(data_width)
   ) i_result (
      .pclk        (pclk),
      .arst_n      (arst_n),
      .launch      (launch),
      .exec_result (exec_result),
      .exec_flags  (exec_flags),
      .result      (result),
      .flags       (flags)
   );

endmodule

// File: testbench/tb_clock_gen.sv
// testbench clock and reset generator, free running clock and counted reset
`timescale 1ns/1ns
module tb_clock_gen #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 16
) (
   output logic pclk,
   output logic arst_n
);

   initial begin
      pclk = 1'b0;
      forever #(period_ns / 2) pclk = ~pclk;
   end

   // release on a rising edge after the reset window
   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge pclk);
      arst_n <= 1'b1;
   end

endmodule

// File: testbench/alu_apb_properties.sv
// alu apb checker, reference model of the register map with concurrent assertions
`timescale 1ns/1ns
module alu_apb_properties import alu_pkg::*; #(
   parameter int data_width = 32
) (
   input logic                      pclk,
   input logic                      arst_n,
   input logic                      psel,
   input logic                      penable,
   input logic                      pwrite,
   input logic [apb_addr_width-1:0] paddr,
   input logic [data_width-1:0]     pwdata,
   input logic [data_width-1:0]     prdata,
   input logic                      pready,
   input logic                      pslverr,
   input string                     test_name
);

   localparam int msb = data_width - 1;

   bit                    fail_seen;
   logic [data_width-1:0] m_a;
   logic [data_width-1:0] m_b;
   logic [data_width-1:0] m_result;
   logic [num_flags-1:0]  m_flags;
   logic [data_width-1:0] calc_result;
   logic [num_flags-1:0]  calc_flags;
   logic [data_width-1:0] exp_rdata;
   logic                  exp_err;
   logic                  access;
   logic                  op_ok;
   logic                  mapped;

   // arithmetic rules written out from the x86 style definitions
   function automatic void model_op(input logic [2:0] code,
                                    input logic [data_width-1:0] a,
                                    input logic [data_width-1:0] b,
                                    output logic [data_width-1:0] res,
                                    output logic [num_flags-1:0] flg);
      logic [data_width:0] wide;
      logic [4:0]          nib;
      int                  cnt;
      cnt = int'(b[$clog2(data_width)-1:0]);
      flg = '0;
      res = '0;
      case (code)
         op_add: begin
            wide          = {1'b0, a} + {1'b0, b};
            res           = wide[msb:0];
            nib           = {1'b0, a[3:0]} + {1'b0, b[3:0]};
            flg[flag_cf]  = wide[data_width];
            flg[flag_af]  = nib[4];
            flg[flag_of]  = (a[msb] == b[msb]) && (res[msb] != a[msb]);
         end
         op_sub: begin
            res           = a - b;
            // borrow out of the whole word and out of the low nibble
            flg[flag_cf]  = a < b;
            flg[flag_af]  = a[3:0] < b[3:0];
            flg[flag_of]  = (a[msb] != b[msb]) && (res[msb] != a[msb]);
         end
         op_sal: res = a << cnt;
         op_shr: res = a >> cnt;
         op_sar: res = $signed(a) >>> cnt;
         default: res = '0;
      endcase
      flg[flag_zf] = (res == '0);
      flg[flag_sf] = res[msb];
   endfunction

   assign access = psel & penable;
   assign op_ok  = pwdata[2:0] <= 3'd4;
   assign mapped = (paddr == addr_operand_a) || (paddr == addr_operand_b) ||
                   (paddr == addr_control) || (paddr == addr_result) ||
                   (paddr == addr_flags);

   always_comb model_op(pwdata[2:0], m_a, m_b, calc_result, calc_flags);

   always_comb begin
      exp_err = !mapped;
      if (pwrite && (paddr == addr_result || paddr == addr_flags))
         exp_err = 1'b1;
      if (pwrite && paddr == addr_control && !op_ok)
         exp_err = 1'b1;
      case (paddr)
         addr_operand_a: exp_rdata = m_a;
         addr_operand_b: exp_rdata = m_b;
         addr_result:    exp_rdata = m_result;
         addr_flags:     exp_rdata = data_width'(m_flags);
         default:        exp_rdata = '0;
      endcase
   end

   // shadow of completed writes
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         m_a      <= '0;
         m_b      <= '0;
         m_result <= '0;
         m_flags  <= '0;
      end else if (access && pwrite) begin
         if (paddr == addr_operand_a)
            m_a <= pwdata;
         if (paddr == addr_operand_b)
            m_b <= pwdata;
         if (paddr == addr_control && op_ok) begin
            m_result <= calc_result;
            m_flags  <= calc_flags;
         end
      end
   end

   a_pready: assert property (@(posedge pclk) disable iff (!arst_n) pready)
      else begin
         fail_seen = 1'b1;
         $error("pready dropped low in %s", test_name);
      end

   a_idle_no_err: assert property (@(posedge pclk) disable iff (!arst_n)
                                   !access |-> !pslverr)
      else begin
         fail_seen = 1'b1;
         $error("pslverr high outside an access phase in %s", test_name);
      end

   a_pslverr: assert property (@(posedge pclk) disable iff (!arst_n)
                               access |-> pslverr == exp_err)
      else begin
         fail_seen = 1'b1;
         $error("mismatch pslverr in %s: expected %b, actual %b", test_name,
                $sampled(exp_err), $sampled(pslverr));
      end

   a_rdata: assert property (@(posedge pclk) disable iff (!arst_n)
                             (access && !pwrite && !exp_err) |-> prdata == exp_rdata)
      else begin
         fail_seen = 1'b1;
         $error("mismatch prdata in %s at 0x%h: expected %h, actual %h", test_name,
                $sampled(paddr), $sampled(exp_rdata), $sampled(prdata));
      end

endmodule

// File: testbench/tb_alu_apb.sv
// alu apb testbench top, apb stimulus with checking done by the bound checker
`timescale 1ns/1ns
module tb_alu_apb import alu_pkg::*;;

   localparam int data_width = 32;
   // reset 4, add/sub 28 ops, shifts 96 ops, errors 17, write-read 21
   localparam int planned_transfers = 4 + 28 * 5 + 96 * 5 + 17 + 21;
   localparam int max_cycles        = 10 * 2 * planned_transfers;

   logic                      pclk;
   logic                      arst_n;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [apb_addr_width-1:0] paddr;
   logic [data_width-1:0]     pwdata;
   logic [data_width-1:0]     prdata;
   logic                      pready;
   logic                      pslverr;
   string                     test_name;
   int                        cycle_count;

   tb_clock_gen #(
      .period_ns    (40),
      .reset_cycles (16)
   ) i_clock (
      .pclk   (pclk),
      .arst_n (arst_n)
   );

   alu_apb_top #(
      .data_width(data_width)
   ) i_dut (
      .pclk    (pclk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   bind alu_apb_top alu_apb_properties #(
      .data_width(data_width)
   ) i_props (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .test_name (tb_alu_apb.test_name)
   );

   // called just after a rising edge, returns on the completing edge
   task automatic apb_transfer(input logic write, input logic [apb_addr_width-1:0] addr,
                               input logic [data_width-1:0] data);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge pclk);
      penable <= 1'b1;
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_write(input logic [apb_addr_width-1:0] addr,
                            input logic [data_width-1:0] data);
      apb_transfer(1'b1, addr, data);
   endtask

   task automatic apb_read(input logic [apb_addr_width-1:0] addr);
      apb_transfer(1'b0, addr, '0);
   endtask

   task automatic run_op(input logic [2:0] code, input logic [data_width-1:0] a,
                         input logic [data_width-1:0] b);
      apb_write(addr_operand_a, a);
      apb_write(addr_operand_b, b);
      apb_write(addr_control, data_width'(code));
      apb_read(addr_result);
      apb_read(addr_flags);
   endtask

   always @(posedge pclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("Test failed");
         $fatal(1, "timeout, run still going after %0d cycles", max_cycles);
      end
   end

   initial begin
      wait (i_dut.i_props.fail_seen === 1'b1);
      $display("Test failed");
      $fatal(1, "checker assertion failed in %s", test_name);
   end

   initial begin
      logic [data_width-1:0] data;
      logic [2:0]            code;
      void'($urandom(95));
      cycle_count = 0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      test_name   = "reset";
      wait (arst_n === 1'b1);
      @(posedge pclk);
      apb_read(addr_result);
      apb_read(addr_flags);
      apb_read(addr_operand_a);
      apb_read(addr_operand_b);

      test_name = "add_sub";
      run_op(op_add, 32'hFFFF_FFFF, 32'h1);
      run_op(op_add, 32'h7FFF_FFFF, 32'h1);
      run_op(op_sub, 32'h1234_5678, 32'h1234_5678);
      run_op(op_sub, 32'h0, 32'h1);
      for (int i = 0; i < 24; i++) begin
         code = (i % 2 == 0) ? op_add : op_sub;
         run_op(code, $urandom, $urandom);
      end

      test_name = "shifts";
      for (int k = 0; k < 3; k++) begin
         code = (k == 0) ? op_sal : ((k == 1) ? op_shr : op_sar);
         for (int cnt = 0; cnt < 32; cnt++) begin
            data = $urandom;
            // odd counts use data with the sign bit set
            if (cnt % 2 == 1)
               data = data | 32'h8000_0000;
            run_op(code, data, ($urandom & ~32'h1F) | cnt);
         end
      end

      test_name = "errors";
      run_op(op_add, 32'h0000_1111, 32'h0000_2222);
      // new operand so a stray launch would change the result
      apb_write(addr_operand_a, 32'h4444_0000);
      apb_read(5'h14);
      apb_read(5'h02);
      apb_write(5'h18, $urandom);
      apb_write(addr_result, $urandom);
      apb_write(addr_flags, $urandom);
      apb_write(addr_control, 32'h5);
      apb_write(addr_control, 32'h6);
      apb_write(addr_control, 32'h7);
      apb_read(addr_result);
      apb_read(addr_flags);
      apb_read(addr_control);

      test_name = "write_read";
      for (int i = 0; i < 3; i++) begin
         apb_write(addr_operand_a, $urandom);
         apb_read(addr_operand_a);
         apb_write(addr_operand_b, $urandom);
         apb_read(addr_operand_b);
         apb_write(addr_control, data_width'(op_sub));
         apb_read(addr_result);
         apb_read(addr_flags);
      end

      // let the last assertions settle
      repeat (2) @(posedge pclk);
      if (i_dut.i_props.fail_seen) begin
         $display("Test failed");
         $fatal(1, "checker reported a failure");
      end else begin
         $display("Test completed successfully");
         $finish;
      end
   end

endmodule

// File: vlog.f
source/alu_pkg.sv
source/alu_cla_adder.sv
source/alu_barrel_shifter.sv
source/alu_exec.sv
source/alu_apb_regs.sv
source/alu_result_regs.sv
source/alu_apb_top.sv
testbench/tb_clock_gen.sv
testbench/alu_apb_properties.sv
testbench/tb_alu_apb.sv

// File: Bender.yml
package:
  name: alu_apb

sources:
  - source/alu_pkg.sv
  - source/alu_cla_adder.sv
  - source/alu_barrel_shifter.sv
  - source/alu_exec.sv
  - source/alu_apb_regs.sv
  - source/alu_result_regs.sv
  - source/alu_apb_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/alu_apb_properties.sv
      - testbench/tb_alu_apb.sv
